// ==== verilog/streamer_config.svh ====
// Tensor streamer configuration
`ifndef STREAMER_CONFIG_SVH
`define STREAMER_CONFIG_SVH

// Memory word address width
`define STREAMER_ADDR_W 16

// Memory and stream data width
`define STREAMER_DATA_W 64

// Transfer length counter width
`define STREAMER_LEN_W 12

// Load channel FIFO depth
`define STREAMER_LOAD_DEPTH 4

// Store channel FIFO depth
`define STREAMER_STORE_DEPTH 2

// Arbiter inputs, ordered X, W, Y, Z
`define STREAMER_N_PORTS 4

`endif

// ==== verilog/streamer_pkg.sv ====
// Tensor streamer types
`include "streamer_config.svh"

package streamer_pkg;

  typedef enum logic {
    CAST_FP16 = 1'b0,
    CAST_FP8  = 1'b1
  } cast_mode_e;

  // One memory word as four FP16 lanes or as four E5M2 lanes
  // in the low half
  typedef union packed {
    logic [3:0][15:0] fp16;
    struct packed {
      logic [31:0]     pad;
      logic [3:0][7:0] lane;
    } fp8;
  } mem_word_u;

  typedef struct packed {
    logic [`STREAMER_ADDR_W-1:0] base;
    logic [`STREAMER_ADDR_W-1:0] stride;
    logic [`STREAMER_LEN_W-1:0]  len;
  } chan_ctrl_t;

  typedef struct packed {
    chan_ctrl_t x;
    chan_ctrl_t w;
    chan_ctrl_t y;
    chan_ctrl_t z;
    cast_mode_e cast_mode;
  } streamer_ctrl_t;

  typedef struct packed {
    logic x_done;
    logic w_done;
    logic y_done;
    logic z_done;
  } streamer_flags_t;

  // wen low means write
  typedef struct packed {
    logic                        req;
    logic                        wen;
    logic [`STREAMER_ADDR_W-1:0] addr;
    logic [`STREAMER_DATA_W-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                        gnt;
    logic                        r_valid;
    logic [`STREAMER_DATA_W-1:0] r_data;
  } mem_rsp_t;

  typedef struct packed {
    logic                        valid;
    logic [`STREAMER_DATA_W-1:0] data;
    logic                        last;
  } stream_t;

endpackage

// ==== verilog/stream_fifo.sv ====
// Synchronous stream FIFO
`timescale 1ns/10ps

module stream_fifo #(
  parameter int unsigned DEPTH = 4,
  parameter int unsigned WIDTH = 64
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       clear_i,
  input  logic                       push_i,
  input  logic [WIDTH-1:0]           data_i,
  output logic                       full_o,
  input  logic                       pop_i,
  output logic [WIDTH-1:0]           data_o,
  output logic                       empty_o,
  output logic [$clog2(DEPTH+1)-1:0] free_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  // Pointers wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign free_o  = CNT_W'(DEPTH) - count_q;
  assign data_o  = mem_q[rd_ptr_q];

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== verilog/load_source.sv ====
// Load channel source
`timescale 1ns/10ps
`include "streamer_config.svh"

module load_source (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        start_i,
  input  streamer_pkg::chan_ctrl_t    ctrl_i,
  input  streamer_pkg::cast_mode_e    cast_mode_i,
  output streamer_pkg::mem_req_t      req_o,
  input  logic                        gnt_i,
  input  logic                        rvalid_i,
  input  logic [`STREAMER_DATA_W-1:0] rdata_i,
  output streamer_pkg::stream_t       stream_o,
  input  logic                        ready_i,
  output logic                        done_o
);

  import streamer_pkg::*;

  localparam int unsigned CNT_W = $clog2(`STREAMER_LOAD_DEPTH + 1);

  chan_ctrl_t                  cfg_q;
  cast_mode_e                  mode_q;
  logic                        active_q;
  logic [`STREAMER_ADDR_W-1:0] addr_q;
  logic [`STREAMER_LEN_W-1:0]  issued_q;
  logic [`STREAMER_LEN_W-1:0]  beats_q;
  logic [CNT_W-1:0]            inflight_q;
  logic [CNT_W-1:0]            fifo_free;
  logic                        fifo_empty;
  logic [`STREAMER_DATA_W-1:0] fifo_dout;
  mem_word_u                   raw_word;
  mem_word_u                   cast_word;
  logic                        credit_ok;
  logic                        issue;
  logic                        pop;
  logic                        last_beat;

  // Credit is free FIFO slots minus reads still in flight
  assign credit_ok = fifo_free > inflight_q;

  assign req_o.req   = active_q & (issued_q != cfg_q.len) & credit_ok;
  assign req_o.wen   = 1'b1;
  assign req_o.addr  = addr_q;
  assign req_o.wdata = '0;
  assign issue       = req_o.req & gnt_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cfg_q      <= '0;
      mode_q     <= CAST_FP16;
      active_q   <= 1'b0;
      issued_q   <= '0;
      beats_q    <= '0;
      inflight_q <= '0;
    end else if (start_i) begin
      cfg_q      <= ctrl_i;
      mode_q     <= cast_mode_i;
      active_q   <= (ctrl_i.len != '0);
      issued_q   <= '0;
      beats_q    <= '0;
      inflight_q <= '0;
    end else begin
      inflight_q <= inflight_q + CNT_W'(issue) - CNT_W'(rvalid_i);
      if (issue) begin
        issued_q <= issued_q + 1'b1;
      end
      if (pop) begin
        beats_q <= beats_q + 1'b1;
      end
      if (done_o) begin
        active_q <= 1'b0;
      end
    end
  end

  // Word address walks base + k * stride
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q <= ctrl_i.base;
    end else if (issue) begin
      addr_q <= addr_q + cfg_q.stride;
    end
  end

  stream_fifo #(
    .DEPTH ( `STREAMER_LOAD_DEPTH ),
    .WIDTH ( `STREAMER_DATA_W     )
  ) i_load_fifo (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .clear_i ( start_i    ),
    .push_i  ( rvalid_i   ),
    .data_i  ( rdata_i    ),
    .full_o  (            ),
    .pop_i   ( pop        ),
    .data_o  ( fifo_dout  ),
    .empty_o ( fifo_empty ),
    .free_o  ( fifo_free  )
  );

  // Input cast widens E5M2 to FP16 by appending a zero byte
  assign raw_word = fifo_dout;

  always_comb begin
    cast_word = raw_word;
    if (mode_q == CAST_FP8) begin
      for (int i = 0; i < 4; i++) begin
        cast_word.fp16[i] = {raw_word.fp8.lane[i], 8'h00};
      end
    end
  end

  assign last_beat = (beats_q == cfg_q.len - 1'b1);

  assign stream_o.valid = ~fifo_empty;
  assign stream_o.data  = cast_word;
  assign stream_o.last  = ~fifo_empty & last_beat;

  assign pop    = stream_o.valid & ready_i;
  assign done_o = pop & last_beat;

endmodule

// ==== verilog/store_sink.sv ====
// Store channel sink
`timescale 1ns/10ps
`include "streamer_config.svh"

module store_sink (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     start_i,
  input  streamer_pkg::chan_ctrl_t ctrl_i,
  input  streamer_pkg::cast_mode_e cast_mode_i,
  input  streamer_pkg::stream_t    stream_i,
  output logic                     ready_o,
  output streamer_pkg::mem_req_t   req_o,
  input  logic                     gnt_i,
  output logic                     done_o
);

  import streamer_pkg::*;

  chan_ctrl_t                  cfg_q;
  cast_mode_e                  mode_q;
  logic                        active_q;
  logic [`STREAMER_ADDR_W-1:0] addr_q;
  logic [`STREAMER_LEN_W-1:0]  taken_q;
  logic [`STREAMER_LEN_W-1:0]  written_q;
  mem_word_u                   in_word;
  mem_word_u                   out_word;
  logic                        fifo_full;
  logic                        fifo_empty;
  logic [`STREAMER_DATA_W-1:0] fifo_dout;
  logic                        accept;
  logic                        write;

  // Take beats only inside a job and while there is room
  assign ready_o = active_q & (taken_q != cfg_q.len) & ~fifo_full;
  assign accept  = stream_i.valid & ready_o;

  // Output cast keeps the upper byte of each FP16 lane as E5M2
  assign in_word = stream_i.data;

  always_comb begin
    out_word = in_word;
    if (mode_q == CAST_FP8) begin
      out_word.fp8.pad = '0;
      for (int i = 0; i < 4; i++) begin
        out_word.fp8.lane[i] = in_word.fp16[i][15:8];
      end
    end
  end

  stream_fifo #(
    .DEPTH ( `STREAMER_STORE_DEPTH ),
    .WIDTH ( `STREAMER_DATA_W      )
  ) i_store_fifo (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .clear_i ( start_i    ),
    .push_i  ( accept     ),
    .data_i  ( out_word   ),
    .full_o  ( fifo_full  ),
    .pop_i   ( write      ),
    .data_o  ( fifo_dout  ),
    .empty_o ( fifo_empty ),
    .free_o  (            )
  );

  assign req_o.req   = ~fifo_empty;
  assign req_o.wen   = 1'b0;
  assign req_o.addr  = addr_q;
  assign req_o.wdata = fifo_dout;
  assign write       = req_o.req & gnt_i;

  // Final write granted
  assign done_o = write & (written_q == cfg_q.len - 1'b1);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cfg_q     <= '0;
      mode_q    <= CAST_FP16;
      active_q  <= 1'b0;
      taken_q   <= '0;
      written_q <= '0;
    end else if (start_i) begin
      cfg_q     <= ctrl_i;
      mode_q    <= cast_mode_i;
      active_q  <= (ctrl_i.len != '0);
      taken_q   <= '0;
      written_q <= '0;
    end else begin
      if (accept) begin
        taken_q <= taken_q + 1'b1;
      end
      if (write) begin
        written_q <= written_q + 1'b1;
      end
      if (done_o) begin
        active_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q <= ctrl_i.base;
    end else if (write) begin
      addr_q <= addr_q + cfg_q.stride;
    end
  end

endmodule

// ==== verilog/tcdm_arbiter.sv ====
// Memory port arbiter
`timescale 1ns/10ps
`include "streamer_config.svh"

module tcdm_arbiter (
  input  logic                                            clk_i,
  input  logic                                            rst_n_i,
  input  streamer_pkg::mem_req_t [`STREAMER_N_PORTS-1:0] port_req_i,
  output logic [`STREAMER_N_PORTS-1:0]                    port_gnt_o,
  output logic [`STREAMER_N_PORTS-1:0]                    port_rvalid_o,
  output logic [`STREAMER_DATA_W-1:0]                     port_rdata_o,
  output streamer_pkg::mem_req_t                          mem_req_o,
  input  streamer_pkg::mem_rsp_t                          mem_rsp_i
);

  localparam int unsigned N  = `STREAMER_N_PORTS;
  localparam int unsigned PW = $clog2(N);
  // Three round-robin slots, X, W and the Y/Z pair
  localparam int unsigned N_SLOTS = 3;
  localparam int unsigned P_X = 0;
  localparam int unsigned P_W = 1;
  localparam int unsigned P_Y = 2;
  localparam int unsigned P_Z = 3;

  logic [N_SLOTS-1:0] slot_req;
  logic [1:0]         rr_ptr_q;
  logic [1:0]         slot_pick;
  logic [1:0]         grant_slot;
  logic [PW-1:0]      port_pick;
  logic [PW-1:0]      sel_port;
  logic [PW-1:0]      lock_port_q;
  logic [PW-1:0]      rd_port_q;
  logic               any_req;
  logic               lock_q;
  logic               granted;
  logic               rd_pend_q;

  function automatic logic [1:0] slot_add(logic [1:0] base, logic [1:0] k);
    logic [2:0] sum;
    sum = {1'b0, base} + {1'b0, k};
    return (sum >= 3'd3) ? 2'(sum - 3'd3) : sum[1:0];
  endfunction

  assign slot_req = {port_req_i[P_Z].req | port_req_i[P_Y].req,
                     port_req_i[P_W].req,
                     port_req_i[P_X].req};
  assign any_req  = |slot_req;

  // First requesting slot at or after the pointer
  always_comb begin
    slot_pick = rr_ptr_q;
    for (int k = N_SLOTS - 1; k >= 0; k--) begin
      if (slot_req[slot_add(rr_ptr_q, 2'(k))]) begin
        slot_pick = slot_add(rr_ptr_q, 2'(k));
      end
    end
  end

  // Z wins over Y inside the shared slot
  always_comb begin
    case (slot_pick)
      2'd0:    port_pick = PW'(P_X);
      2'd1:    port_pick = PW'(P_W);
      default: port_pick = port_req_i[P_Z].req ? PW'(P_Z) : PW'(P_Y);
    endcase
  end

  // A stalled request keeps the port until it is granted
  assign sel_port   = lock_q ? lock_port_q : port_pick;
  assign grant_slot = (sel_port >= PW'(P_Y)) ? 2'd2 : 2'(sel_port);

  assign mem_req_o = any_req ? port_req_i[sel_port] : '0;
  assign granted   = mem_req_o.req & mem_rsp_i.gnt;

  assign port_gnt_o    = {N{granted}} & (N'(1) << sel_port);
  assign port_rvalid_o = {N{mem_rsp_i.r_valid & rd_pend_q}} & (N'(1) << rd_port_q);
  assign port_rdata_o  = mem_rsp_i.r_data;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_ptr_q    <= '0;
      lock_q      <= 1'b0;
      lock_port_q <= '0;
      rd_pend_q   <= 1'b0;
      rd_port_q   <= '0;
    end else begin
      lock_q      <= mem_req_o.req & ~mem_rsp_i.gnt;
      lock_port_q <= sel_port;
      // Owner of the read data due next cycle
      rd_pend_q   <= granted & mem_req_o.wen;
      rd_port_q   <= sel_port;
      if (granted) begin
        rr_ptr_q <= slot_add(grant_slot, 2'd1);
      end
    end
  end

endmodule

// ==== verilog/tensor_streamer.sv ====
// Tensor streamer top level
`timescale 1ns/10ps
`include "streamer_config.svh"

module tensor_streamer (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         start_i,
  input  streamer_pkg::streamer_ctrl_t ctrl_i,
  output streamer_pkg::stream_t        x_stream_o,
  output streamer_pkg::stream_t        w_stream_o,
  output streamer_pkg::stream_t        y_stream_o,
  input  logic                         x_ready_i,
  input  logic                         w_ready_i,
  input  logic                         y_ready_i,
  input  streamer_pkg::stream_t        z_stream_i,
  output logic                         z_ready_o,
  output streamer_pkg::mem_req_t       mem_req_o,
  input  streamer_pkg::mem_rsp_t       mem_rsp_i,
  output streamer_pkg::streamer_flags_t flags_o
);

  import streamer_pkg::*;

  // Load channels take the first arbiter ports, the store channel the last
  localparam int unsigned N_LOAD = `STREAMER_N_PORTS - 1;
  localparam int unsigned Z_PORT = `STREAMER_N_PORTS - 1;

  mem_req_t [`STREAMER_N_PORTS-1:0] port_req;
  logic [`STREAMER_N_PORTS-1:0]     port_gnt;
  logic [`STREAMER_N_PORTS-1:0]     port_rvalid;
  logic [`STREAMER_DATA_W-1:0]      port_rdata;

  chan_ctrl_t [N_LOAD-1:0] load_ctrl;
  stream_t [N_LOAD-1:0]    load_stream;
  logic [N_LOAD-1:0]       load_ready;
  logic [N_LOAD-1:0]       load_done;
  logic                    store_done;

  // Index 0 is X, 1 is W, 2 is Y
  assign load_ctrl  = {ctrl_i.y, ctrl_i.w, ctrl_i.x};
  assign load_ready = {y_ready_i, w_ready_i, x_ready_i};

  assign x_stream_o = load_stream[0];
  assign w_stream_o = load_stream[1];
  assign y_stream_o = load_stream[2];

  for (genvar i = 0; i < N_LOAD; i++) begin : gen_load
    load_source i_load_source (
      .clk_i       ( clk_i            ),
      .rst_n_i     ( rst_n_i          ),
      .start_i     ( start_i          ),
      .ctrl_i      ( load_ctrl[i]     ),
      .cast_mode_i ( ctrl_i.cast_mode ),
      .req_o       ( port_req[i]      ),
      .gnt_i       ( port_gnt[i]      ),
      .rvalid_i    ( port_rvalid[i]   ),
      .rdata_i     ( port_rdata       ),
      .stream_o    ( load_stream[i]   ),
      .ready_i     ( load_ready[i]    ),
      .done_o      ( load_done[i]     )
    );
  end

  store_sink i_store_sink (
    .clk_i       ( clk_i              ),
    .rst_n_i     ( rst_n_i            ),
    .start_i     ( start_i            ),
    .ctrl_i      ( ctrl_i.z           ),
    .cast_mode_i ( ctrl_i.cast_mode   ),
    .stream_i    ( z_stream_i         ),
    .ready_o     ( z_ready_o          ),
    .req_o       ( port_req[Z_PORT]   ),
    .gnt_i       ( port_gnt[Z_PORT]   ),
    .done_o      ( store_done         )
  );

  tcdm_arbiter i_tcdm_arbiter (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .port_req_i    ( port_req    ),
    .port_gnt_o    ( port_gnt    ),
    .port_rvalid_o ( port_rvalid ),
    .port_rdata_o  ( port_rdata  ),
    .mem_req_o     ( mem_req_o   ),
    .mem_rsp_i     ( mem_rsp_i   )
  );

  assign flags_o.x_done = load_done[0];
  assign flags_o.w_done = load_done[1];
  assign flags_o.y_done = load_done[2];
  assign flags_o.z_done = store_done;

endmodule

// ==== testbench/tensor_streamer_chk.sv ====
// Tensor streamer port assertions
`timescale 1ns/10ps

module tensor_streamer_chk (
  input logic                          clk_i,
  input logic                          rst_n_i,
  input streamer_pkg::stream_t         x_stream_o,
  input streamer_pkg::stream_t         w_stream_o,
  input streamer_pkg::stream_t         y_stream_o,
  input logic                          x_ready_i,
  input logic                          w_ready_i,
  input logic                          y_ready_i,
  input logic                          z_ready_o,
  input streamer_pkg::mem_req_t        mem_req_o,
  input streamer_pkg::mem_rsp_t        mem_rsp_i,
  input streamer_pkg::streamer_flags_t flags_o
);

  // Stalled load beats hold valid, data and last
  x_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    x_stream_o.valid && !x_ready_i |=>
      x_stream_o.valid && $stable(x_stream_o.data) && $stable(x_stream_o.last))
    else $error("x_stream_o changed while stalled");

  w_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    w_stream_o.valid && !w_ready_i |=>
      w_stream_o.valid && $stable(w_stream_o.data) && $stable(w_stream_o.last))
    else $error("w_stream_o changed while stalled");

  y_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    y_stream_o.valid && !y_ready_i |=>
      y_stream_o.valid && $stable(y_stream_o.data) && $stable(y_stream_o.last))
    else $error("y_stream_o changed while stalled");

  // Memory request waits unchanged for its grant
  req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_o.req && !mem_rsp_i.gnt |=> $stable(mem_req_o))
    else $error("mem_req_o changed before gnt");

  reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |=> !mem_req_o.req && !x_stream_o.valid && !w_stream_o.valid &&
                 !y_stream_o.valid && !z_ready_o && flags_o == '0)
    else $error("Outputs active after reset");

  // Done flags are one-cycle pulses
  x_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flags_o.x_done |=> !flags_o.x_done)
    else $error("x_done held for more than one cycle");

  w_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flags_o.w_done |=> !flags_o.w_done)
    else $error("w_done held for more than one cycle");

  y_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flags_o.y_done |=> !flags_o.y_done)
    else $error("y_done held for more than one cycle");

  z_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flags_o.z_done |=> !flags_o.z_done)
    else $error("z_done held for more than one cycle");

endmodule

bind tensor_streamer tensor_streamer_chk tensor_streamer_chk_inst (
  .clk_i      ( clk_i      ),
  .rst_n_i    ( rst_n_i    ),
  .x_stream_o ( x_stream_o ),
  .w_stream_o ( w_stream_o ),
  .y_stream_o ( y_stream_o ),
  .x_ready_i  ( x_ready_i  ),
  .w_ready_i  ( w_ready_i  ),
  .y_ready_i  ( y_ready_i  ),
  .z_ready_o  ( z_ready_o  ),
  .mem_req_o  ( mem_req_o  ),
  .mem_rsp_i  ( mem_rsp_i  ),
  .flags_o    ( flags_o    )
);

// ==== testbench/tensor_streamer_tb.sv ====
// Tensor streamer testbench
`timescale 1ns/10ps
`include "streamer_config.svh"

module tensor_streamer_tb;

  import streamer_pkg::*;

  localparam int N_TESTS = 5;
  localparam int N_COLS  = 15;
  localparam int CLK_NS  = 20;

  logic            clk_i = 1'b0;
  logic            rst_n_i;
  logic            start_i;
  streamer_ctrl_t  ctrl_i;
  stream_t         x_stream_o;
  stream_t         w_stream_o;
  stream_t         y_stream_o;
  logic            x_ready_i;
  logic            w_ready_i;
  logic            y_ready_i;
  stream_t         z_stream_i;
  logic            z_ready_o;
  mem_req_t        mem_req_o;
  mem_rsp_t        mem_rsp_i;
  streamer_flags_t flags_o;

  // Columns: cast mode (1 is FP8), base, stride and len for X, W, Y and Z,
  // Z data seed, stall percentage for ready, Z valid and gnt
  int test_table [N_TESTS][N_COLS] = '{
    '{0, 'h0100, 1, 8,  'h0200, 2, 8, 'h0300, 3, 8,  'h8000, 1, 8,  'h1234, 0},
    '{1, 'h0400, 1, 10, 'h0500, 4, 6, 'hfffa, 1, 12, 'h8100, 2, 9,  'h5a5a, 30},
    '{0, 'h0600, 2, 16, 'h0700, 1, 0, 'h0800, 7, 5,  'h8200, 1, 0,  'h0f0f, 50},
    '{1, 'h0900, 1, 0,  'h0a00, 3, 7, 'h0b00, 1, 9,  'h8300, 3, 12, 'h7777, 40},
    '{0, 'h0100, 1, 8,  'h0200, 2, 8, 'h0300, 3, 8,  'h8400, 1, 8,  'h1234, 20}
  };

  logic [`STREAMER_DATA_W-1:0] mem [0:65535];
  logic [31:0]                 rng_state = 32'd67024;
  logic [31:0]                 z_state = 32'd0;
  int                          errors = 0;
  int                          checks = 0;
  int                          stall_pct = 0;
  cast_mode_e                  cur_mode = CAST_FP16;

  // Load channel bookkeeping, index 0 is X, 1 is W, 2 is Y
  logic [15:0] ld_base [3];
  logic [15:0] ld_stride [3];
  int          ld_len [3] = '{0, 0, 0};
  int          ld_idx [3] = '{0, 0, 0};
  string       ld_name [3] = '{"x_stream_o", "w_stream_o", "y_stream_o"};

  logic [15:0] z_base = '0;
  logic [15:0] z_stride = '0;
  int          z_len = 0;
  int          z_taken = 0;
  int          z_writes = 0;
  logic [63:0] z_exp [$];

  tensor_streamer tensor_streamer_inst (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .start_i    ( start_i    ),
    .ctrl_i     ( ctrl_i     ),
    .x_stream_o ( x_stream_o ),
    .w_stream_o ( w_stream_o ),
    .y_stream_o ( y_stream_o ),
    .x_ready_i  ( x_ready_i  ),
    .w_ready_i  ( w_ready_i  ),
    .y_ready_i  ( y_ready_i  ),
    .z_stream_i ( z_stream_i ),
    .z_ready_o  ( z_ready_o  ),
    .mem_req_o  ( mem_req_o  ),
    .mem_rsp_i  ( mem_rsp_i  ),
    .flags_o    ( flags_o    )
  );

  always #(CLK_NS / 2) clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int roll_pct();
    rng_state = lcg_next(rng_state);
    return int'(rng_state[30:16] % 100);
  endfunction

  // E5M2 byte k of the low half becomes the top byte of FP16 lane k
  function automatic logic [63:0] widen_fp8(logic [63:0] w);
    logic [63:0] r;
    int          i;
    for (i = 0; i < 4; i++) begin
      r[16*i +: 16] = {w[8*i +: 8], 8'h00};
    end
    return r;
  endfunction

  function automatic logic [63:0] narrow_fp16(logic [63:0] w);
    logic [63:0] r;
    int          i;
    r = '0;
    for (i = 0; i < 4; i++) begin
      r[8*i +: 8] = w[16*i + 8 +: 8];
    end
    return r;
  endfunction

  function automatic chan_ctrl_t row_chan(int t, int col);
    chan_ctrl_t cc;
    cc.base   = 16'(test_table[t][col]);
    cc.stride = 16'(test_table[t][col + 1]);
    cc.len    = 12'(test_table[t][col + 2]);
    return cc;
  endfunction

  function automatic streamer_ctrl_t row_ctrl(int t);
    streamer_ctrl_t c;
    c.cast_mode = (test_table[t][0] != 0) ? CAST_FP8 : CAST_FP16;
    c.x = row_chan(t, 1);
    c.w = row_chan(t, 4);
    c.y = row_chan(t, 7);
    c.z = row_chan(t, 10);
    return c;
  endfunction

  function automatic int total_words();
    int sum;
    int t;
    sum = 0;
    for (t = 0; t < N_TESTS; t++) begin
      sum += test_table[t][3] + test_table[t][6] + test_table[t][9] + test_table[t][12];
    end
    return sum;
  endfunction

  function automatic logic job_finished();
    int i;
    for (i = 0; i < 3; i++) begin
      if (ld_idx[i] != ld_len[i]) begin
        return 1'b0;
      end
    end
    return z_writes == z_len;
  endfunction

  task automatic check_word(input string name, input mem_word_u exp, input mem_word_u act);
    checks++;
    if (act !== exp) begin
      $display("ERROR t=%0t %s expected=%h actual=%h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_stream(input string name, input stream_t exp, input stream_t act);
    checks++;
    if (act !== exp) begin
      $display("ERROR t=%0t %s expected=%h actual=%h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flags(input string name, input streamer_flags_t exp,
                             input streamer_flags_t act);
    checks++;
    if (act !== exp) begin
      $display("ERROR t=%0t %s expected=%b actual=%b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic fill_memory();
    int a;
    for (a = 0; a < 65536; a++) begin
      rng_state = lcg_next(rng_state);
      mem[a][63:32] = rng_state;
      rng_state = lcg_next(rng_state);
      mem[a][31:0] = rng_state ^ 32'(a);
    end
  endtask

  // Compare one transferred load beat against the model word
  task automatic watch_load(input int ch, input stream_t s, input logic rdy,
                            output logic done_exp);
    stream_t     exp;
    logic [15:0] addr;
    done_exp = 1'b0;
    if (s.valid && rdy) begin
      if (ld_idx[ch] >= ld_len[ch]) begin
        $display("%s delivered a beat beyond its length at %0t", ld_name[ch], $time);
        errors++;
      end else begin
        addr = ld_base[ch] + ld_stride[ch] * 16'(ld_idx[ch]);
        exp.valid = 1'b1;
        exp.data  = (cur_mode == CAST_FP8) ? widen_fp8(mem[addr]) : mem[addr];
        exp.last  = (ld_idx[ch] == ld_len[ch] - 1);
        check_stream(ld_name[ch], exp, s);
        done_exp = exp.last;
        ld_idx[ch]++;
      end
    end
  endtask

  task automatic arm_load(input int ch, input chan_ctrl_t cc);
    ld_base[ch]   = cc.base;
    ld_stride[ch] = cc.stride;
    ld_len[ch]    = int'(cc.len);
    ld_idx[ch]    = 0;
  endtask

  // Memory model, consumers, Z producer and per-cycle checks
  always @(posedge clk_i) begin : bench_step
    streamer_flags_t exp_flags;
    logic            pulse;
    logic [63:0]     z_word;
    if (rst_n_i) begin
      exp_flags = '0;
      watch_load(0, x_stream_o, x_ready_i, pulse);
      exp_flags.x_done = pulse;
      watch_load(1, w_stream_o, w_ready_i, pulse);
      exp_flags.w_done = pulse;
      watch_load(2, y_stream_o, y_ready_i, pulse);
      exp_flags.y_done = pulse;

      if (z_stream_i.valid && z_ready_o) begin
        z_exp.push_back((cur_mode == CAST_FP8) ? narrow_fp16(z_stream_i.data)
                                               : z_stream_i.data);
        z_taken++;
      end

      // Read data returns exactly one cycle after the grant
      mem_rsp_i.r_valid <= 1'b0;
      if (mem_req_o.req && mem_rsp_i.gnt) begin
        if (mem_req_o.wen) begin
          mem_rsp_i.r_valid <= 1'b1;
          mem_rsp_i.r_data  <= mem[mem_req_o.addr];
        end else begin
          if (z_writes >= z_len) begin
            $display("Store channel wrote more words than its length at %0t", $time);
            errors++;
          end else begin
            check_word("mem_req_o.wdata", z_exp[z_writes], mem_req_o.wdata);
            exp_flags.z_done = (z_writes == z_len - 1);
          end
          mem[mem_req_o.addr] = mem_req_o.wdata;
          z_writes++;
        end
      end
      check_flags("flags_o", exp_flags, flags_o);

      // A new Z beat once the previous one is gone
      if (!z_stream_i.valid || z_ready_o) begin
        if (z_taken < z_len && roll_pct() >= stall_pct) begin
          z_state = lcg_next(z_state);
          z_word[63:32] = z_state;
          z_state = lcg_next(z_state);
          z_word[31:0] = z_state;
          z_stream_i.valid <= 1'b1;
          z_stream_i.data  <= z_word;
          z_stream_i.last  <= (z_taken == z_len - 1);
        end else begin
          z_stream_i.valid <= 1'b0;
          z_stream_i.last  <= 1'b0;
        end
      end
    end
    x_ready_i     <= (roll_pct() >= stall_pct);
    w_ready_i     <= (roll_pct() >= stall_pct);
    y_ready_i     <= (roll_pct() >= stall_pct);
    mem_rsp_i.gnt <= (roll_pct() >= stall_pct);
  end

  task automatic run_test(input int t);
    streamer_ctrl_t c;
    int             errs_before;
    int             k;
    logic [15:0]    addr;
    string          mode_name;
    c = row_ctrl(t);
    errs_before = errors;
    mode_name = (c.cast_mode == CAST_FP8) ? "fp8" : "fp16";
    @(negedge clk_i);
    cur_mode  = c.cast_mode;
    stall_pct = test_table[t][14];
    arm_load(0, c.x);
    arm_load(1, c.w);
    arm_load(2, c.y);
    z_base   = c.z.base;
    z_stride = c.z.stride;
    z_len    = int'(c.z.len);
    z_taken  = 0;
    z_writes = 0;
    z_state  = 32'(test_table[t][13]);
    z_exp.delete();
    @(posedge clk_i);
    ctrl_i  <= c;
    start_i <= 1'b1;
    @(posedge clk_i);
    start_i <= 1'b0;
    @(negedge clk_i);
    while (!job_finished()) begin
      @(negedge clk_i);
    end
    // Idle cycles catch late beats and stray done pulses
    repeat (4) @(negedge clk_i);
    for (k = 0; k < z_len; k++) begin
      addr = z_base + z_stride * 16'(k);
      check_word($sformatf("mem[%h]", addr), z_exp[k], mem[addr]);
    end
    $display("test %0d %s: %0d error(s)", t, mode_name, errors - errs_before);
  endtask

  initial begin : main
    int t;
    rst_n_i    <= 1'b0;
    start_i    <= 1'b0;
    ctrl_i     <= '0;
    x_ready_i  <= 1'b0;
    w_ready_i  <= 1'b0;
    y_ready_i  <= 1'b0;
    z_stream_i <= '0;
    mem_rsp_i  <= '0;
    fill_memory();
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    for (t = 0; t < N_TESTS; t++) begin
      run_test(t);
    end
    $display("Summary: %0d tests, %0d checks, %0d errors", N_TESTS, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // 40 cycles per word plus a little start and idle time per test
  initial begin : watchdog
    int limit;
    limit = 40 * total_words() + 30 * N_TESTS + 10;
    #(limit * CLK_NS);
    $display("Watchdog expired, the run did not finish within %0d cycles", limit);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+verilog
verilog/streamer_pkg.sv
verilog/stream_fifo.sv
verilog/load_source.sv
verilog/store_sink.sv
verilog/tcdm_arbiter.sv
verilog/tensor_streamer.sv
testbench/tensor_streamer_chk.sv
testbench/tensor_streamer_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the tensor streamer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f all.f --top-module tensor_streamer_tb -o tensor_streamer_sim

out=$(./obj_dir/tensor_streamer_sim)
echo "$out"

if echo "$out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1
